// File: project.f
+incdir+bench
rtl/decode_pkg.sv
rtl/instr_decoder.sv
rtl/immediate_extract.sv
rtl/program_counter.sv
rtl/operand_select.sv
rtl/stage_register.sv
rtl/decode_stage.sv
bench/decode_tb.sv

// File: Bender.yml
package:
  name: decode_stage

sources:
  - rtl/decode_pkg.sv
  - rtl/instr_decoder.sv
  - rtl/immediate_extract.sv
  - rtl/program_counter.sv
  - rtl/operand_select.sv
  - rtl/stage_register.sv
  - rtl/decode_stage.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/decode_tb.sv

// File: bench/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// ----------------------------------------
// Reference decode for the RV32 subset
// ----------------------------------------
function automatic logic [UOP_W-1:0] alu_op_for(input logic [2:0] f3);
    case (f3)
        3'b000:  return ALU_ADD;
        3'b001:  return ALU_SLL;
        3'b010:  return ALU_SLT;
        3'b011:  return ALU_SLTU;
        3'b100:  return ALU_XOR;
        3'b101:  return ALU_SRL;
        3'b110:  return ALU_OR;
        default: return ALU_AND;
    endcase
endfunction

// Bundle order: rd, opr a/b/c, uop, fu, trap, rs1, rs2, instruction word
function automatic logic [STAGE_W-1:0] model_decode(input logic [31:0] w, input logic err,
                                                    input logic [XLEN-1:0] pc);
    logic [2:0]       f3;
    logic [6:0]       f7;
    logic             ok;
    logic             trap;
    logic [FU_W-1:0]  fu;
    logic [UOP_W-1:0] uop;
    logic [REG_W-1:0] rd;
    logic [REG_W-1:0] a1;
    logic [REG_W-1:0] a2;
    logic [XLEN-1:0]  a;
    logic [XLEN-1:0]  b;
    logic [XLEN-1:0]  c;
    logic [XLEN-1:0]  imm_i;
    logic [XLEN-1:0]  imm_u;
    logic [1:0]       width;
    f3    = w[14:12];
    f7    = w[31:25];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_u = {w[31:12], 12'b0};
    width = (f3[1:0] == 2'b00) ? LSU_BYTE : (f3[1:0] == 2'b01) ? LSU_HALF : LSU_WORD;
    ok    = 1'b1;
    fu    = '0;
    uop   = '0;
    rd    = w[11:7];
    a1    = '0;
    a2    = '0;
    b     = '0;
    c     = '0;
    case (w[6:0])
        OPC_OP: begin
            fu[FU_ALU] = 1'b1;
            a1         = w[19:15];
            a2         = w[24:20];
            b          = reg_value(a2);
            if (f7 == 7'h00) uop = alu_op_for(f3);
            else if (f7 == 7'h20 && f3 == 3'b000) uop = ALU_SUB;
            else if (f7 == 7'h20 && f3 == 3'b101) uop = ALU_SRA;
            else ok = 1'b0;
        end
        OPC_OP_IMM: begin
            fu[FU_ALU] = 1'b1;
            a1         = w[19:15];
            b          = imm_i;
            uop        = alu_op_for(f3);
            if (f3 == 3'b001) begin
                b  = {27'b0, w[24:20]};          // Shift amount
                ok = f7 == 7'h00;
            end else if (f3 == 3'b101) begin
                b = {27'b0, w[24:20]};
                if (f7 == 7'h20) uop = ALU_SRA;
                else ok = f7 == 7'h00;
            end
        end
        OPC_LUI: begin
            fu[FU_ALU] = 1'b1;
            uop        = ALU_OR;
            b          = imm_u;
        end
        OPC_AUIPC: begin
            fu[FU_ALU] = 1'b1;
            uop        = ALU_ADD;
        end
        OPC_LOAD: begin
            fu[FU_LSU]      = 1'b1;
            a1              = w[19:15];
            b               = imm_i;
            uop[LSU_LOAD]   = 1'b1;
            uop[2:1]        = width;
            uop[LSU_SIGNED] = !f3[2] && !f3[1];   // lb and lh only
            ok              = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        end
        OPC_STORE: begin
            fu[FU_LSU]     = 1'b1;
            a1             = w[19:15];
            a2             = w[24:20];
            b              = {{20{w[31]}}, w[31:25], w[11:7]};
            c              = reg_value(a2);
            uop[LSU_STORE] = 1'b1;
            uop[2:1]       = width;
            rd             = '0;
            ok             = f3 < 3'd3;
        end
        OPC_BRANCH: begin
            fu[FU_CFU] = 1'b1;
            a1         = w[19:15];
            a2         = w[24:20];
            b          = reg_value(a2);
            c          = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            rd         = '0;
            case (f3)
                3'b000:  uop = CFU_BEQ;
                3'b001:  uop = CFU_BNE;
                3'b100:  uop = CFU_BLT;
                3'b101:  uop = CFU_BGE;
                3'b110:  uop = CFU_BLTU;
                3'b111:  uop = CFU_BGEU;
                default: ok  = 1'b0;
            endcase
        end
        OPC_JAL: begin
            fu[FU_CFU] = 1'b1;
            uop        = CFU_JALI;
            c          = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        OPC_JALR: begin
            fu[FU_CFU] = 1'b1;
            uop        = CFU_JALR;
            a1         = w[19:15];
            b          = imm_i;
            ok         = f3 == 3'b000;
        end
        default: ok = 1'b0;
    endcase
    a = (w[6:0] == OPC_AUIPC) ? pc + imm_u : reg_value(a1);   // x0 reads as zero
    trap = err || !ok;
    if (trap) begin
        fu  = '0;
        uop = '0;
        a1  = '0;
        a2  = '0;
        a   = '0;
        b   = '0;
        c   = '0;
        rd  = err ? TRAP_IACCESS : TRAP_IOPCODE;   // Fetch error first
    end
    return {rd, a, b, c, uop, fu, trap, a1, a2, w};
endfunction

`endif

// File: bench/decode_tb.sv
`timescale 1ns/100ps

module decode_tb import decode_pkg::*; ();

    localparam int N_INSTR    = 2000;                   // Items taken before pass
    localparam int CLK_PERIOD = 10;
    localparam int TIMEOUT    = N_INSTR * 8 * CLK_PERIOD;

    logic             g_clk;
    logic             g_resetn;
    logic             i_s1_valid;
    logic             o_s1_busy;
    logic [XLEN-1:0]  i_s1_data;
    logic             i_s1_error;
    logic             i_s1_flush;
    logic [REG_W-1:0] o_s1_rs1_addr;
    logic [REG_W-1:0] o_s1_rs2_addr;
    logic [XLEN-1:0]  i_s1_rs1_rdata;
    logic [XLEN-1:0]  i_s1_rs2_rdata;
    logic             i_cf_req;
    logic [XLEN-1:0]  i_cf_target;
    logic             i_cf_ack;
    logic             o_s2_valid;
    logic             i_s2_busy;
    logic [REG_W-1:0] o_s2_rd;
    logic [XLEN-1:0]  o_s2_opr_a;
    logic [XLEN-1:0]  o_s2_opr_b;
    logic [XLEN-1:0]  o_s2_opr_c;
    logic [UOP_W-1:0] o_s2_uop;
    logic [FU_W-1:0]  o_s2_fu;
    logic             o_s2_trap;
    logic [REG_W-1:0] o_s2_rs1_addr;
    logic [REG_W-1:0] o_s2_rs2_addr;
    logic [XLEN-1:0]  o_s2_instr;

    logic [31:0]        rng;
    logic [XLEN-1:0]    model_pc;
    logic [STAGE_W-1:0] expect_q[$];                    // Accepted, not yet taken
    int                 taken;
    int                 item_no;

    decode_stage decode_stage_i (.*);

    always #(CLK_PERIOD / 2) g_clk = ~g_clk;

    // Register file stand-in
    function automatic logic [XLEN-1:0] reg_value(input logic [REG_W-1:0] addr);
        return (addr == '0) ? '0 : ((32'h9e37_79b9 * {27'b0, addr}) ^ {addr, 27'h0});
    endfunction

    assign i_s1_rs1_rdata = reg_value(o_s1_rs1_addr);
    assign i_s1_rs2_rdata = reg_value(o_s1_rs2_addr);

    `include "decode_model.svh"

    // ----------------------------------------
    // Random stimulus
    // ----------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] rand_next();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [31:0] make_instr();
        logic [31:0] body;
        logic [3:0]  pick;
        logic [6:0]  opc;
        logic [6:0]  f7;
        body = rand_next();
        pick = rand_next() % 16;
        f7   = (body[1:0] == 2'b00) ? body[31:25] : (body[2] ? 7'h20 : 7'h00);
        case (pick)
            0, 1:    opc = OPC_OP;
            2, 3:    opc = OPC_OP_IMM;
            4:       opc = OPC_LUI;
            5:       opc = OPC_AUIPC;
            6, 7:    opc = OPC_LOAD;
            8, 9:    opc = OPC_STORE;
            10, 11:  opc = OPC_BRANCH;
            12:      opc = OPC_JAL;
            13:      opc = OPC_JALR;
            default: return body;                       // Mostly illegal words
        endcase
        if (opc == OPC_OP || opc == OPC_OP_IMM) body[31:25] = f7;
        return {body[31:7], opc};
    endfunction

    task automatic drive_inputs();
        i_s1_valid  = (rand_next() % 8) != 0;
        i_s1_data   = make_instr();
        i_s1_error  = (rand_next() % 16) == 0;
        i_s2_busy   = (rand_next() % 4) == 0;
        i_s1_flush  = (rand_next() % 32) == 0;
        i_cf_req    = (rand_next() % 16) == 0;
        i_cf_ack    = (rand_next() % 2) == 0;           // Unacked requests change nothing
        i_cf_target = rand_next() & ~32'h3;
    endtask

    // ----------------------------------------
    // Checking
    // ----------------------------------------
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_outputs(input logic [STAGE_W-1:0] exp, input int idx);
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic [XLEN-1:0]  a;
        logic [XLEN-1:0]  b;
        logic [XLEN-1:0]  c;
        logic [XLEN-1:0]  w;
        logic [UOP_W-1:0] uop;
        logic [FU_W-1:0]  fu;
        logic             trap;
        {rd, a, b, c, uop, fu, trap, rs1, rs2, w} = exp;
        check_value($sformatf("item %0d instr", idx), w, o_s2_instr);
        check_value($sformatf("item %0d rd", idx), rd, o_s2_rd);
        check_value($sformatf("item %0d opr_a", idx), a, o_s2_opr_a);
        check_value($sformatf("item %0d opr_b", idx), b, o_s2_opr_b);
        check_value($sformatf("item %0d opr_c", idx), c, o_s2_opr_c);
        check_value($sformatf("item %0d uop", idx), uop, o_s2_uop);
        check_value($sformatf("item %0d fu", idx), fu, o_s2_fu);
        check_value($sformatf("item %0d trap", idx), trap, o_s2_trap);
        check_value($sformatf("item %0d rs1_addr", idx), rs1, o_s2_rs1_addr);
        check_value($sformatf("item %0d rs2_addr", idx), rs2, o_s2_rs2_addr);
    endtask

    // Runs just before the edge, with all inputs settled
    task automatic sample_cycle();
        logic [STAGE_W-1:0] now_exp;
        logic               accept;
        now_exp = model_decode(i_s1_data, i_s1_error, model_pc);
        accept  = i_s1_valid && !i_s2_busy && !i_s1_flush;
        check_value("s1 rs1 address", now_exp[XLEN+REG_W +: REG_W], o_s1_rs1_addr);
        check_value("s1 rs2 address", now_exp[XLEN +: REG_W], o_s1_rs2_addr);
        check_value("s1 busy", i_s2_busy || i_s1_flush, o_s1_busy);
        if (o_s2_valid) begin
            if (expect_q.size() == 0) begin
                fail_run("Output valid although no instruction was accepted");
            end else begin
                check_outputs(expect_q[0], item_no);
                if (i_s1_flush || !i_s2_busy) begin     // Flushed or taken
                    void'(expect_q.pop_front());
                    item_no++;
                    if (!i_s1_flush) taken++;
                end
            end
        end else if (expect_q.size() != 0) begin
            fail_run("An accepted instruction never reached the outputs");
        end
        if (accept) expect_q.push_back(now_exp);
        if (i_cf_req && i_cf_ack) begin
            model_pc = i_cf_target;                     // Redirect wins
        end else if (accept) begin
            model_pc = model_pc + 32'd4;
        end
    endtask

    // ----------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------
    initial begin
        g_clk       = 1'b0;
        g_resetn    = 1'b0;
        i_s1_valid  = 1'b0;
        i_s1_data   = '0;
        i_s1_error  = 1'b0;
        i_s1_flush  = 1'b0;
        i_cf_req    = 1'b0;
        i_cf_target = '0;
        i_cf_ack    = 1'b0;
        i_s2_busy   = 1'b0;
        rng         = 32'd86;
        model_pc    = RESET_PC;
        taken       = 0;
        item_no     = 0;
        repeat (16) @(posedge g_clk);
        #1;
        g_resetn = 1'b1;
        drive_inputs();
        #(CLK_PERIOD - 2);
        check_value("reset o_s2_valid", 0, o_s2_valid);
        check_value("reset o_s2_trap", 0, o_s2_trap);
        while (taken < N_INSTR) begin
            sample_cycle();
            @(posedge g_clk);
            #1;
            drive_inputs();
            #(CLK_PERIOD - 2);
        end
        $display("Regression passed");
        $finish;
    end

    initial begin
        #(TIMEOUT);
        fail_run($sformatf("Watchdog expired with %0d of %0d items taken", taken, N_INSTR));
    end

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/100ps

module decode_stage import decode_pkg::*; (
    input  logic             g_clk,
    input  logic             g_resetn,
    input  logic             i_s1_valid,
    output logic             o_s1_busy,
    input  logic [XLEN-1:0]  i_s1_data,
    input  logic             i_s1_error,
    input  logic             i_s1_flush,
    output logic [REG_W-1:0] o_s1_rs1_addr,
    output logic [REG_W-1:0] o_s1_rs2_addr,
    input  logic [XLEN-1:0]  i_s1_rs1_rdata,
    input  logic [XLEN-1:0]  i_s1_rs2_rdata,
    input  logic             i_cf_req,        // Control flow change request
    input  logic [XLEN-1:0]  i_cf_target,
    input  logic             i_cf_ack,
    output logic             o_s2_valid,
    input  logic             i_s2_busy,
    output logic [REG_W-1:0] o_s2_rd,         // Trap cause on a trap
    output logic [XLEN-1:0]  o_s2_opr_a,
    output logic [XLEN-1:0]  o_s2_opr_b,
    output logic [XLEN-1:0]  o_s2_opr_c,
    output logic [UOP_W-1:0] o_s2_uop,
    output logic [FU_W-1:0]  o_s2_fu,
    output logic             o_s2_trap,
    output logic [REG_W-1:0] o_s2_rs1_addr,
    output logic [REG_W-1:0] o_s2_rs2_addr,
    output logic [XLEN-1:0]  o_s2_instr
);

    logic [FU_W-1:0]    dec_fu;
    logic [UOP_W-1:0]   dec_uop;
    logic [REG_W-1:0]   dec_rd;
    logic               dec_trap;
    logic [1:0]         opra_sel;
    logic [1:0]         oprb_sel;
    logic [1:0]         oprc_sel;
    logic [XLEN-1:0]    imm;
    logic [XLEN-1:0]    pc_imm;
    logic [XLEN-1:0]    pc_plus_imm;
    logic [XLEN-1:0]    opr_a;
    logic [XLEN-1:0]    opr_b;
    logic [XLEN-1:0]    opr_c;
    logic               advance;
    logic [STAGE_W-1:0] s1_bundle;
    logic [STAGE_W-1:0] s2_bundle;

    assign advance = i_s1_valid && !o_s1_busy;  // Item accepted this cycle

    instr_decoder instr_decoder_i (
        .i_instr    (i_s1_data),
        .i_error    (i_s1_error),
        .o_fu       (dec_fu),
        .o_uop      (dec_uop),
        .o_rd       (dec_rd),
        .o_rs1_addr (o_s1_rs1_addr),
        .o_rs2_addr (o_s1_rs2_addr),
        .o_opra_sel (opra_sel),
        .o_oprb_sel (oprb_sel),
        .o_oprc_sel (oprc_sel),
        .o_trap     (dec_trap)
    );

    immediate_extract immediate_extract_i (
        .i_instr  (i_s1_data),
        .o_imm    (imm),
        .o_pc_imm (pc_imm)
    );

    program_counter program_counter_i (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .i_advance     (advance),
        .i_cf_req      (i_cf_req),
        .i_cf_ack      (i_cf_ack),
        .i_cf_target   (i_cf_target),
        .i_pc_imm      (pc_imm),
        .o_pc_plus_imm (pc_plus_imm)
    );

    operand_select operand_select_i (
        .i_opra_sel    (opra_sel),
        .i_oprb_sel    (oprb_sel),
        .i_oprc_sel    (oprc_sel),
        .i_rs1_rdata   (i_s1_rs1_rdata),
        .i_rs2_rdata   (i_s1_rs2_rdata),
        .i_imm         (imm),
        .i_pc_plus_imm (pc_plus_imm),
        .o_opr_a       (opr_a),
        .o_opr_b       (opr_b),
        .o_opr_c       (opr_c)
    );

    // ----------------------------------------
    // Stage register bundle
    // ----------------------------------------
    assign s1_bundle = {dec_rd, opr_a, opr_b, opr_c, dec_uop, dec_fu, dec_trap,
                        o_s1_rs1_addr, o_s1_rs2_addr, i_s1_data};

    assign {o_s2_rd, o_s2_opr_a, o_s2_opr_b, o_s2_opr_c, o_s2_uop, o_s2_fu, o_s2_trap,
            o_s2_rs1_addr, o_s2_rs2_addr, o_s2_instr} = s2_bundle;

    stage_register #(
        .WIDTH (STAGE_W)
    ) stage_register_i (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_valid  (i_s1_valid),
        .i_data   (s1_bundle),
        .i_flush  (i_s1_flush),
        .i_busy   (i_s2_busy),
        .o_valid  (o_s2_valid),
        .o_data   (s2_bundle),
        .o_busy   (o_s1_busy)
    );

endmodule

// File: rtl/stage_register.sv
`timescale 1ns/100ps

module stage_register #(
    parameter int WIDTH = 8
) (
    input  logic             g_clk,
    input  logic             g_resetn,
    input  logic             i_valid,
    input  logic [WIDTH-1:0] i_data,
    input  logic             i_flush,     // Drop the held item
    input  logic             i_busy,      // Next stage stalled
    output logic             o_valid,
    output logic [WIDTH-1:0] o_data,
    output logic             o_busy
);

    assign o_busy = i_busy || i_flush;

    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            o_valid <= 1'b0;
        end else if (!o_busy) begin
            o_valid <= i_valid;
        end
    end

    // Payload, loaded on an accept
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            o_data <= '0;
        end else if (i_valid && !o_busy) begin
            o_data <= i_data;
        end
    end

    assert property (@(posedge g_clk) disable iff (!g_resetn)
        o_valid && i_busy && !i_flush |=> $stable(o_data))
        else $error("stage_register: held data changed under back-pressure");

endmodule

// File: rtl/operand_select.sv
`timescale 1ns/100ps

module operand_select import decode_pkg::*; (
    input  logic [1:0]      i_opra_sel,
    input  logic [1:0]      i_oprb_sel,
    input  logic [1:0]      i_oprc_sel,
    input  logic [XLEN-1:0] i_rs1_rdata,
    input  logic [XLEN-1:0] i_rs2_rdata,
    input  logic [XLEN-1:0] i_imm,
    input  logic [XLEN-1:0] i_pc_plus_imm,
    output logic [XLEN-1:0] o_opr_a,
    output logic [XLEN-1:0] o_opr_b,
    output logic [XLEN-1:0] o_opr_c
);

    always_comb begin
        case (i_opra_sel)
            OPRA_RS1:  o_opr_a = i_rs1_rdata;
            OPRA_PCIM: o_opr_a = i_pc_plus_imm;   // auipc result
            default:   o_opr_a = '0;
        endcase

        case (i_oprb_sel)
            OPRB_RS2: o_opr_b = i_rs2_rdata;
            OPRB_IMM: o_opr_b = i_imm;
            default:  o_opr_b = '0;
        endcase

        case (i_oprc_sel)
            OPRC_RS2:  o_opr_c = i_rs2_rdata;     // Store data
            OPRC_PCIM: o_opr_c = i_pc_plus_imm;   // Branch or jump target
            default:   o_opr_c = '0;
        endcase
    end

endmodule

// File: rtl/program_counter.sv
`timescale 1ns/100ps

module program_counter import decode_pkg::*; (
    input  logic            g_clk,
    input  logic            g_resetn,
    input  logic            i_advance,      // Instruction accepted
    input  logic            i_cf_req,
    input  logic            i_cf_ack,
    input  logic [XLEN-1:0] i_cf_target,
    input  logic [XLEN-1:0] i_pc_imm,
    output logic [XLEN-1:0] o_pc_plus_imm
);

    logic [XLEN-1:0] pc;

    // Redirect wins over the sequential advance
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc <= RESET_PC;
        end else if (i_cf_req && i_cf_ack) begin
            pc <= i_cf_target;
        end else if (i_advance) begin
            pc <= pc + XLEN'(4);
        end
    end

    assign o_pc_plus_imm = pc + i_pc_imm;   // Old PC for this cycle's item

endmodule

// File: rtl/immediate_extract.sv
`timescale 1ns/100ps

module immediate_extract import decode_pkg::*; (
    input  instr_t          i_instr,
    output logic [XLEN-1:0] o_imm,
    output logic [XLEN-1:0] o_pc_imm      // Added to the PC
);

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_shamt;
    logic            is_shift;

    assign imm_i = {{20{i_instr.i.imm_11_0[11]}}, i_instr.i.imm_11_0};
    assign imm_s = {{20{i_instr.s.imm_11_5[6]}}, i_instr.s.imm_11_5, i_instr.s.imm_4_0};
    assign imm_b = {{19{i_instr.b.imm_12}}, i_instr.b.imm_12, i_instr.b.imm_11,
                    i_instr.b.imm_10_5, i_instr.b.imm_4_1, 1'b0};
    assign imm_u = {i_instr.u.imm_31_12, 12'b0};
    assign imm_j = {{11{i_instr.j.imm_20}}, i_instr.j.imm_20, i_instr.j.imm_19_12,
                    i_instr.j.imm_11, i_instr.j.imm_10_1, 1'b0};
    assign imm_shamt = {27'b0, i_instr.r.rs2};  // Shift amount sits in rs2 slot

    assign is_shift = i_instr.r.opcode == OPC_OP_IMM && i_instr.r.funct3[1:0] == 2'b01;

    always_comb begin
        case (i_instr.u.opcode)
            OPC_OP_IMM:         o_imm = is_shift ? imm_shamt : imm_i;
            OPC_LOAD, OPC_JALR: o_imm = imm_i;
            OPC_STORE:          o_imm = imm_s;
            OPC_LUI, OPC_AUIPC: o_imm = imm_u;
            default:            o_imm = '0;
        endcase
        case (i_instr.u.opcode)
            OPC_BRANCH: o_pc_imm = imm_b;
            OPC_JAL:    o_pc_imm = imm_j;
            OPC_AUIPC:  o_pc_imm = imm_u;
            default:    o_pc_imm = '0;
        endcase
    end

endmodule

// File: rtl/instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder import decode_pkg::*; (
    input  instr_t           i_instr,
    input  logic             i_error,     // Fetch error on this word
    output logic [FU_W-1:0]  o_fu,
    output logic [UOP_W-1:0] o_uop,
    output logic [REG_W-1:0] o_rd,
    output logic [REG_W-1:0] o_rs1_addr,
    output logic [REG_W-1:0] o_rs2_addr,
    output logic [1:0]       o_opra_sel,
    output logic [1:0]       o_oprb_sel,
    output logic [1:0]       o_oprc_sel,
    output logic             o_trap
);

    logic             legal;              // Word matched a kept instruction
    logic             rd_used;
    logic [FU_W-1:0]  fu;
    logic [UOP_W-1:0] uop;
    logic [1:0]       opra_sel;
    logic [1:0]       oprb_sel;
    logic [1:0]       oprc_sel;
    logic [2:0]       funct3;
    logic [6:0]       funct7;

    assign funct3 = i_instr.r.funct3;
    assign funct7 = i_instr.r.funct7;

    // ALU op selected by funct3 with funct7 all zero
    function automatic logic [UOP_W-1:0] alu_base(input logic [2:0] f3);
        case (f3)
            3'b000:  return ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic logic [1:0] lsu_width(input logic [1:0] f3_low);
        case (f3_low)
            2'b00:   return LSU_BYTE;
            2'b01:   return LSU_HALF;
            default: return LSU_WORD;
        endcase
    endfunction

    // ----------------------------------------
    // Opcode and funct matching
    // ----------------------------------------
    always_comb begin
        legal    = 1'b1;
        rd_used  = 1'b1;
        fu       = '0;
        uop      = '0;
        opra_sel = OPRA_ZERO;
        oprb_sel = OPRB_ZERO;
        oprc_sel = OPRC_ZERO;
        case (i_instr.r.opcode)
            OPC_OP: begin
                fu[FU_ALU] = 1'b1;
                opra_sel   = OPRA_RS1;
                oprb_sel   = OPRB_RS2;
                if (funct7 == 7'h00) begin
                    uop = alu_base(funct3);
                end else if (funct7 == 7'h20 && funct3 == 3'b000) begin
                    uop = ALU_SUB;
                end else if (funct7 == 7'h20 && funct3 == 3'b101) begin
                    uop = ALU_SRA;
                end else begin
                    legal = 1'b0;
                end
            end
            OPC_OP_IMM: begin
                fu[FU_ALU] = 1'b1;
                opra_sel   = OPRA_RS1;
                oprb_sel   = OPRB_IMM;
                uop        = alu_base(funct3);
                if (funct3 == 3'b101 && funct7 == 7'h20) begin
                    uop = ALU_SRA;
                end else if (funct3[1:0] == 2'b01 && funct7 != 7'h00) begin
                    legal = 1'b0;                     // Shift with bad funct7
                end
            end
            OPC_LUI: begin
                fu[FU_ALU] = 1'b1;
                uop        = ALU_OR;                  // Zero OR immediate
                oprb_sel   = OPRB_IMM;
            end
            OPC_AUIPC: begin
                fu[FU_ALU] = 1'b1;
                uop        = ALU_ADD;
                opra_sel   = OPRA_PCIM;
            end
            OPC_LOAD: begin
                fu[FU_LSU]      = 1'b1;
                opra_sel        = OPRA_RS1;
                oprb_sel        = OPRB_IMM;
                uop[LSU_LOAD]   = 1'b1;
                uop[LSU_SIGNED] = funct3 == 3'b000 || funct3 == 3'b001;  // lb, lh
                uop[2:1]        = lsu_width(funct3[1:0]);
                legal           = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
            end
            OPC_STORE: begin
                fu[FU_LSU]     = 1'b1;
                opra_sel       = OPRA_RS1;
                oprb_sel       = OPRB_IMM;
                oprc_sel       = OPRC_RS2;            // Store data
                uop[LSU_STORE] = 1'b1;
                uop[2:1]       = lsu_width(funct3[1:0]);
                rd_used        = 1'b0;
                legal          = funct3 inside {3'b000, 3'b001, 3'b010};
            end
            OPC_BRANCH: begin
                fu[FU_CFU] = 1'b1;
                opra_sel   = OPRA_RS1;
                oprb_sel   = OPRB_RS2;
                oprc_sel   = OPRC_PCIM;               // Branch target
                rd_used    = 1'b0;
                case (funct3)
                    3'b000:  uop = CFU_BEQ;
                    3'b001:  uop = CFU_BNE;
                    3'b100:  uop = CFU_BLT;
                    3'b101:  uop = CFU_BGE;
                    3'b110:  uop = CFU_BLTU;
                    3'b111:  uop = CFU_BGEU;
                    default: legal = 1'b0;
                endcase
            end
            OPC_JAL: begin
                fu[FU_CFU] = 1'b1;
                uop        = CFU_JALI;
                oprc_sel   = OPRC_PCIM;
            end
            OPC_JALR: begin
                fu[FU_CFU] = 1'b1;
                uop        = CFU_JALR;
                opra_sel   = OPRA_RS1;
                oprb_sel   = OPRB_IMM;
                legal      = funct3 == 3'b000;
            end
            default: legal = 1'b0;
        endcase
    end

    // ----------------------------------------
    // Outputs, masked on a trap
    // ----------------------------------------
    assign o_trap     = i_error || !legal;
    assign o_fu       = o_trap ? '0 : fu;
    assign o_uop      = o_trap ? '0 : uop;
    assign o_opra_sel = o_trap ? OPRA_ZERO : opra_sel;
    assign o_oprb_sel = o_trap ? OPRB_ZERO : oprb_sel;
    assign o_oprc_sel = o_trap ? OPRC_ZERO : oprc_sel;

    // Fetch error outranks an illegal word
    assign o_rd = i_error ? TRAP_IACCESS :
                  !legal  ? TRAP_IOPCODE :
                  rd_used ? i_instr.r.rd : '0;

    assign o_rs1_addr = (o_opra_sel == OPRA_RS1) ? i_instr.r.rs1 : '0;
    assign o_rs2_addr = (o_oprb_sel == OPRB_RS2 || o_oprc_sel == OPRC_RS2) ?
                        i_instr.r.rs2 : '0;

    assert final ($onehot0(o_fu))
        else $error("instr_decoder: unit is not one-hot");
    assert final (o_trap == (o_fu == '0))
        else $error("instr_decoder: unit set on a trap or missing on a legal word");

endmodule

// File: rtl/decode_pkg.sv
package decode_pkg;

    localparam int XLEN  = 32;
    localparam int REG_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

    // ----------------------------------------
    // Major opcodes
    // ----------------------------------------
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // ----------------------------------------
    // Micro-ops
    // ----------------------------------------
    localparam int UOP_W = 7;

    localparam logic [UOP_W-1:0] ALU_ADD  = 7'h01;
    localparam logic [UOP_W-1:0] ALU_SUB  = 7'h02;
    localparam logic [UOP_W-1:0] ALU_AND  = 7'h03;
    localparam logic [UOP_W-1:0] ALU_OR   = 7'h04;
    localparam logic [UOP_W-1:0] ALU_XOR  = 7'h05;
    localparam logic [UOP_W-1:0] ALU_SLT  = 7'h06;
    localparam logic [UOP_W-1:0] ALU_SLTU = 7'h07;
    localparam logic [UOP_W-1:0] ALU_SLL  = 7'h08;
    localparam logic [UOP_W-1:0] ALU_SRL  = 7'h09;
    localparam logic [UOP_W-1:0] ALU_SRA  = 7'h0a;

    localparam logic [UOP_W-1:0] CFU_BEQ  = 7'h01;
    localparam logic [UOP_W-1:0] CFU_BNE  = 7'h02;
    localparam logic [UOP_W-1:0] CFU_BLT  = 7'h03;
    localparam logic [UOP_W-1:0] CFU_BGE  = 7'h04;
    localparam logic [UOP_W-1:0] CFU_BLTU = 7'h05;
    localparam logic [UOP_W-1:0] CFU_BGEU = 7'h06;
    localparam logic [UOP_W-1:0] CFU_JALI = 7'h07;
    localparam logic [UOP_W-1:0] CFU_JALR = 7'h08;

    localparam int LSU_SIGNED = 0;             // Sign extend load data
    localparam int LSU_LOAD   = 3;
    localparam int LSU_STORE  = 4;

    localparam logic [1:0] LSU_BYTE = 2'b01;   // Width codes in uop bits 2:1
    localparam logic [1:0] LSU_HALF = 2'b10;
    localparam logic [1:0] LSU_WORD = 2'b11;

    // ----------------------------------------
    // Functional units and traps
    // ----------------------------------------
    localparam int FU_W   = 3;
    localparam int FU_ALU = 0;
    localparam int FU_LSU = 1;
    localparam int FU_CFU = 2;

    localparam logic [REG_W-1:0] TRAP_IACCESS = 5'd1;
    localparam logic [REG_W-1:0] TRAP_IOPCODE = 5'd2;

    // Operand source selects
    localparam logic [1:0] OPRA_ZERO = 2'd0;
    localparam logic [1:0] OPRA_RS1  = 2'd1;
    localparam logic [1:0] OPRA_PCIM = 2'd2;
    localparam logic [1:0] OPRB_ZERO = 2'd0;
    localparam logic [1:0] OPRB_RS2  = 2'd1;
    localparam logic [1:0] OPRB_IMM  = 2'd2;
    localparam logic [1:0] OPRC_ZERO = 2'd0;
    localparam logic [1:0] OPRC_RS2  = 2'd1;
    localparam logic [1:0] OPRC_PCIM = 2'd2;

    // rd, opr a/b/c, uop, fu, trap, rs1, rs2, instruction word
    localparam int STAGE_W = 3 * REG_W + 4 * XLEN + UOP_W + FU_W + 1;

    // ----------------------------------------
    // Instruction formats
    // ----------------------------------------
    typedef struct packed {
        logic [6:0]       funct7;
        logic [REG_W-1:0] rs2;
        logic [REG_W-1:0] rs1;
        logic [2:0]       funct3;
        logic [REG_W-1:0] rd;
        logic [6:0]       opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0]      imm_11_0;
        logic [REG_W-1:0] rs1;
        logic [2:0]       funct3;
        logic [REG_W-1:0] rd;
        logic [6:0]       opcode;
    } instr_i_t;

    typedef struct packed {
        logic [6:0]       imm_11_5;
        logic [REG_W-1:0] rs2;
        logic [REG_W-1:0] rs1;
        logic [2:0]       funct3;
        logic [4:0]       imm_4_0;
        logic [6:0]       opcode;
    } instr_s_t;

    typedef struct packed {
        logic             imm_12;
        logic [5:0]       imm_10_5;
        logic [REG_W-1:0] rs2;
        logic [REG_W-1:0] rs1;
        logic [2:0]       funct3;
        logic [3:0]       imm_4_1;
        logic             imm_11;
        logic [6:0]       opcode;
    } instr_b_t;

    typedef struct packed {
        logic [19:0]      imm_31_12;
        logic [REG_W-1:0] rd;
        logic [6:0]       opcode;
    } instr_u_t;

    typedef struct packed {
        logic             imm_20;
        logic [9:0]       imm_10_1;
        logic             imm_11;
        logic [7:0]       imm_19_12;
        logic [REG_W-1:0] rd;
        logic [6:0]       opcode;
    } instr_j_t;

    typedef union packed {
        logic [XLEN-1:0] raw;
        instr_r_t        r;
        instr_i_t        i;
        instr_s_t        s;
        instr_b_t        b;
        instr_u_t        u;
        instr_j_t        j;
    } instr_t;

endpackage
